/* flist.f */
+incdir+sim
design/dac_pkg.sv
design/axis_sample_slicer.sv
design/dac_code_formatter.sv
design/dac_ddr_out.sv
design/dac_output_top.sv
sim/tb_dac_output.sv

/* sim/dac_ref_model.svh */
`ifndef DAC_REF_MODEL_SVH
`define DAC_REF_MODEL_SVH

// ====================
// Pipeline model
// ====================

localparam int MODEL_W     = dac_pkg::DAC_DATA_WIDTH;
localparam int MODEL_B_LSB = dac_pkg::chan_b_lsb(dac_pkg::AXIS_DATA_WIDTH);

// Locked as sampled, newest first. Stage 2 gates live.
logic               lock_hist [0:2];
// Expected codes, stage 2 is on the bus.
dac_pkg::dac_code_t hist_a [0:2];
dac_pkg::dac_code_t hist_b [0:2];
// Expected DAC reset, stage 3 is on dac_rst.
logic               rst_hist [0:3];
int                 strobe_age;
int                 live_words;
int                 blank_words;

// Sign bit kept, the rest inverted.
function automatic dac_pkg::dac_code_t model_code(input dac_pkg::dac_code_t sample);
  dac_pkg::dac_code_t flip;
  flip = {1'b0, {(MODEL_W-1){1'b1}}};
  return sample ^ flip;
endfunction

task automatic model_reset();
  for (int i = 0; i < 4; i++)
  begin
    if (i < 3)
    begin
      lock_hist[i] = 1'b0;
      hist_a[i]    = '0;
      hist_b[i]    = '0;
    end
    rst_hist[i] = 1'b1;
  end
  strobe_age  = 0;
  live_words  = 0;
  blank_words = 0;
endtask

// One rising edge with reset released.
task automatic model_step(input dac_pkg::stream_word_t word, input logic valid,
                          input logic lock_in);
  logic live_now;
  for (int i = 3; i > 0; i--)
  begin
    rst_hist[i] = rst_hist[i-1];
    if (i < 3)
    begin
      lock_hist[i] = lock_hist[i-1];
      hist_a[i]    = hist_a[i-1];
      hist_b[i]    = hist_b[i-1];
    end
  end
  lock_hist[0] = lock_in;
  live_now     = valid & lock_hist[2];
  hist_a[0]    = live_now ? model_code(word[MODEL_W-1:0]) : '0;
  hist_b[0]    = live_now ? model_code(word[MODEL_B_LSB +: MODEL_W]) : '0;
  rst_hist[0]  = ~live_now;
  if (live_now)
    live_words++;
  else
    blank_words++;
  if (strobe_age < 2)
    strobe_age++;
endtask

`endif

/* sim/tb_dac_output.sv */
`timescale 1ns/10ps

module tb_dac_output;

  logic                  aclk;
  logic                  arst_n;
  logic                  locked;
  dac_pkg::stream_word_t s_axis_tdata;
  logic                  s_axis_tvalid;
  logic                  dac_clk;
  logic                  dac_rst;
  logic                  dac_sel;
  logic                  dac_wrt;
  dac_pkg::dac_code_t    dac_dat;

  integer seed;
  int     error_count;
  int     drop_left;
  int     rst_rises;
  int     rst_falls;
  logic   seen_rst;

  `include "dac_ref_model.svh"

  dac_output_top #(
    .DAC_WIDTH    (dac_pkg::DAC_DATA_WIDTH),
    .STREAM_WIDTH (dac_pkg::AXIS_DATA_WIDTH)
  ) u_dac_output_top (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .locked        (locked),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .dac_clk       (dac_clk),
    .dac_rst       (dac_rst),
    .dac_sel       (dac_sel),
    .dac_wrt       (dac_wrt),
    .dac_dat       (dac_dat)
  );

  initial
  begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "Simulation stopped on error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("MISMATCH time=%0t signal=%s actual=0x%0h expected=0x%0h",
               $time, name, actual, expected);
      stop_run();
    end
  endtask

  task automatic fail_run(input string reason);
    error_count++;
    $display("ERROR: %s", reason);
    stop_run();
  endtask

  // About 80% of the words are valid.
  function automatic logic random_valid();
    return ({$random(seed)} % 100) < 80;
  endfunction

  // ====================
  // One aclk period
  // ====================

  task automatic run_cycle(input logic rst_n_next, input logic valid_next,
                           input logic locked_next);
    logic exp_stb;
    @(posedge aclk);
    // Inputs still hold what the DUT just sampled.
    if (!arst_n)
      model_reset();
    else
      model_step(s_axis_tdata, s_axis_tvalid, locked);
    arst_n        <= rst_n_next;
    s_axis_tdata  <= $random(seed);
    s_axis_tvalid <= valid_next;
    locked        <= locked_next;
    exp_stb = (strobe_age >= 2);
    #10;
    check_value("dac_dat high", dac_dat, hist_b[2]);
    check_value("dac_sel high", dac_sel, exp_stb);
    check_value("dac_wrt high", dac_wrt, exp_stb);
    check_value("dac_clk high", dac_clk, exp_stb);
    check_value("dac_rst high", dac_rst, rst_hist[3]);
    #20;
    check_value("dac_dat low", dac_dat, hist_a[2]);
    check_value("dac_sel low", dac_sel, 1'b0);
    check_value("dac_wrt low", dac_wrt, 1'b0);
    check_value("dac_clk low", dac_clk, 1'b0);
    check_value("dac_rst low", dac_rst, rst_hist[3]);
    if (dac_rst === 1'b1 && seen_rst === 1'b0)
      rst_rises++;
    if (dac_rst === 1'b0 && seen_rst === 1'b1)
      rst_falls++;
    seen_rst = dac_rst;
  endtask

  task automatic wait_for_rst(input logic level, input logic valid, input logic lock_in,
                              input int max_cycles);
    int n;
    n = 0;
    while (seen_rst !== level && n < max_cycles)
    begin
      run_cycle(1'b1, valid, lock_in);
      n++;
    end
    if (seen_rst !== level)
      fail_run($sformatf("dac_rst did not reach %0b within %0d cycles", level, max_cycles));
  endtask

  // ====================
  // Stimulus
  // ====================

  initial
  begin
    seed          = 96730;
    error_count   = 0;
    drop_left     = 0;
    rst_rises     = 0;
    rst_falls     = 0;
    seen_rst      = 1'b1;
    arst_n        = 1'b0;
    locked        = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    model_reset();

    repeat (15) run_cycle(1'b0, random_valid(), 1'b1);
    run_cycle(1'b1, random_valid(), 1'b1);
    wait_for_rst(1'b0, 1'b1, 1'b1, 20);

    // Random words with short locked drops.
    for (int i = 0; i < 600; i++)
    begin
      if (drop_left > 0)
        drop_left--;
      else if (({$random(seed)} % 64) == 0)
        drop_left = 4 + {$random(seed)} % 12;
      run_cycle(1'b1, random_valid(), drop_left == 0);
    end

    // Directed entry and exit of DAC reset.
    wait_for_rst(1'b0, 1'b1, 1'b1, 20);
    wait_for_rst(1'b1, 1'b1, 1'b0, 20);
    wait_for_rst(1'b0, 1'b1, 1'b1, 20);
    wait_for_rst(1'b1, 1'b0, 1'b1, 20);
    wait_for_rst(1'b0, 1'b1, 1'b1, 20);
    repeat (4) run_cycle(1'b1, 1'b1, 1'b1);

    if (live_words == 0)
      fail_run("no live word reached the DAC bus");
    if (blank_words == 0)
      fail_run("no blanked word was seen");
    if (rst_rises == 0 || rst_falls == 0)
      fail_run("dac_rst did not toggle in both directions");

    if (error_count == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
      stop_run();
  end

endmodule

/* design/dac_output_top.sv */
`timescale 1ns/10ps

module dac_output_top #(
  parameter int DAC_WIDTH    = dac_pkg::DAC_DATA_WIDTH,
  parameter int STREAM_WIDTH = dac_pkg::AXIS_DATA_WIDTH
) (
  input  logic                  aclk,
  input  logic                  arst_n,
  input  logic                  locked,
  input  dac_pkg::stream_word_t s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  dac_clk,
  output logic                  dac_rst,
  output logic                  dac_sel,
  output logic                  dac_wrt,
  output dac_pkg::dac_code_t    dac_dat
);

  dac_pkg::dac_code_t sample_a;
  dac_pkg::dac_code_t sample_b;
  logic               live;

  dac_pkg::dac_code_t code_a;
  dac_pkg::dac_code_t code_b;
  logic               dac_reset;

  // ====================
  // Input side
  // ====================

  axis_sample_slicer #(
    .DAC_WIDTH    (DAC_WIDTH),
    .STREAM_WIDTH (STREAM_WIDTH)
  ) u_slicer (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .locked        (locked),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .sample_a      (sample_a),
    .sample_b      (sample_b),
    .live          (live)
  );

  // Code conversion and reset delay.
  dac_code_formatter #(
    .DAC_WIDTH (DAC_WIDTH)
  ) u_formatter (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .sample_a  (sample_a),
    .sample_b  (sample_b),
    .live      (live),
    .code_a    (code_a),
    .code_b    (code_b),
    .dac_reset (dac_reset)
  );

  // ====================
  // Output side
  // ====================

  dac_ddr_out #(
    .DAC_WIDTH (DAC_WIDTH)
  ) u_ddr_out (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .code_a    (code_a),
    .code_b    (code_b),
    .dac_reset (dac_reset),
    .dac_clk   (dac_clk),
    .dac_rst   (dac_rst),
    .dac_sel   (dac_sel),
    .dac_wrt   (dac_wrt),
    .dac_dat   (dac_dat)
  );

endmodule

/* design/dac_ddr_out.sv */
`timescale 1ns/10ps

module dac_ddr_out #(
  parameter int DAC_WIDTH = dac_pkg::DAC_DATA_WIDTH
) (
  input  logic               aclk,
  input  logic               arst_n,
  input  dac_pkg::dac_code_t code_a,
  input  dac_pkg::dac_code_t code_b,
  input  logic               dac_reset,
  output logic               dac_clk,
  output logic               dac_rst,
  output logic               dac_sel,
  output logic               dac_wrt,
  output dac_pkg::dac_code_t dac_dat
);

  // Strobe bit order in the pair registers.
  localparam int STB_SEL = 0;
  localparam int STB_WRT = 1;
  localparam int STB_CLK = 2;

  logic [DAC_WIDTH-1:0] dat_rise;
  logic [DAC_WIDTH-1:0] dat_fall;
  logic [2:0]           stb_rise;
  logic                 rst_rise;
  logic                 strobe_en;

  // ====================
  // Same-edge capture
  // ====================

  // Both phase values are loaded on the rising edge.
  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dat_rise  <= '0;
      dat_fall  <= '0;
      stb_rise  <= '0;
      rst_rise  <= 1'b1;
      strobe_en <= 1'b0;
    end
    else
    begin
      dat_rise  <= code_b;
      dat_fall  <= code_a;
      // Strobes stay quiet for one period after release.
      stb_rise  <= {3{strobe_en}};
      rst_rise  <= dac_reset;
      strobe_en <= 1'b1;
    end
  end

  // ====================
  // Phase select
  // ====================

  // Channel B on the high phase, channel A on the low phase.
  assign dac_dat = aclk ? dat_rise : dat_fall;

  // Strobes are low for the whole low phase.
  assign dac_sel = aclk & stb_rise[STB_SEL];
  assign dac_wrt = aclk & stb_rise[STB_WRT];
  assign dac_clk = aclk & stb_rise[STB_CLK];

  // Held for the whole period.
  assign dac_rst = rst_rise;

endmodule

/* design/dac_code_formatter.sv */
`timescale 1ns/10ps

module dac_code_formatter #(
  parameter int DAC_WIDTH = dac_pkg::DAC_DATA_WIDTH
) (
  input  logic               aclk,
  input  logic               arst_n,
  input  dac_pkg::dac_code_t sample_a,
  input  dac_pkg::dac_code_t sample_b,
  input  logic               live,
  output dac_pkg::dac_code_t code_a,
  output dac_pkg::dac_code_t code_b,
  output logic               dac_reset
);

  logic rst_stage1;

  // Two's complement to inverted-offset code.
  // Sign bit stays, the magnitude bits flip.
  function automatic dac_pkg::dac_code_t to_dac_code(input dac_pkg::dac_code_t sample);
    return {sample[DAC_WIDTH-1], ~sample[DAC_WIDTH-2:0]};
  endfunction

  // ====================
  // Code registers
  // ====================

  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      code_a <= '0;
      code_b <= '0;
    end
    else if (live)
    begin
      code_a <= to_dac_code(sample_a);
      code_b <= to_dac_code(sample_b);
    end
    else
    begin
      // Blank the bus while no sample is live.
      code_a <= '0;
      code_b <= '0;
    end
  end

  // ====================
  // DAC reset delay
  // ====================

  // One stage behind the codes, so valid data is on the bus before reset drops.
  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rst_stage1 <= 1'b1;
      dac_reset  <= 1'b1;
    end
    else
    begin
      rst_stage1 <= ~live;
      dac_reset  <= rst_stage1;
    end
  end

endmodule

/* design/axis_sample_slicer.sv */
`timescale 1ns/10ps

module axis_sample_slicer #(
  parameter int DAC_WIDTH    = dac_pkg::DAC_DATA_WIDTH,
  parameter int STREAM_WIDTH = dac_pkg::AXIS_DATA_WIDTH
) (
  input  logic                 aclk,
  input  logic                 arst_n,
  input  logic                 locked,
  input  dac_pkg::stream_word_t s_axis_tdata,
  input  logic                 s_axis_tvalid,
  output dac_pkg::dac_code_t   sample_a,
  output dac_pkg::dac_code_t   sample_b,
  output logic                 live
);

  localparam int B_LSB = dac_pkg::chan_b_lsb(STREAM_WIDTH);

  logic locked_meta;
  logic locked_sync;

  // ====================
  // Locked synchronizer
  // ====================

  // Locked comes straight from the clock generator.
  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      locked_meta <= 1'b0;
      locked_sync <= 1'b0;
    end
    else
    begin
      locked_meta <= locked;
      locked_sync <= locked_meta;
    end
  end

  // ====================
  // Sample registers
  // ====================

  // Every word is taken, there is no back-pressure.
  always_ff @(posedge aclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sample_a <= '0;
      sample_b <= '0;
      live     <= 1'b0;
    end
    else
    begin
      sample_a <= s_axis_tdata[DAC_WIDTH-1:0];
      sample_b <= s_axis_tdata[B_LSB +: DAC_WIDTH];
      live     <= s_axis_tvalid & locked_sync;
    end
  end

endmodule

/* design/dac_pkg.sv */
package dac_pkg;

  // ====================
  // Widths
  // ====================

  // DAC code width of the converter.
  localparam int DAC_DATA_WIDTH = 14;

  // One stream word carries both channels.
  localparam int AXIS_DATA_WIDTH = 32;

  // ====================
  // Types
  // ====================

  typedef logic [AXIS_DATA_WIDTH-1:0] stream_word_t;

  // Two's-complement sample or offset-binary DAC code.
  typedef logic [DAC_DATA_WIDTH-1:0] dac_code_t;

  // ====================
  // Channel layout
  // ====================

  // Channel A sits at bit 0, channel B starts in the upper half.
  function automatic int chan_b_lsb(int stream_width = AXIS_DATA_WIDTH);
    return stream_width / 2;
  endfunction

endpackage
